// File: all.f
+incdir+design
design/agc_ctrl_pkg.sv
design/agc_host_regs.sv
design/agc_loop_seq.sv
design/agc_bus_master.sv
design/agc_loop_top.sv
sim/agc_target_model.sv
sim/tb_agc_loop.sv

// File: Bender.yml
package:
  name: agc_loop

export_include_dirs:
  - design

sources:
  - files:
      - design/agc_ctrl_pkg.sv
      - design/agc_host_regs.sv
      - design/agc_loop_seq.sv
      - design/agc_bus_master.sv
      - design/agc_loop_top.sv
  - target: simulation
    files:
      - sim/agc_target_model.sv
      - sim/tb_agc_loop.sv

// File: sim/tb_agc_loop.sv
`timescale 1ns/1ps
`include "agc_ctrl_consts.svh"

module tb_agc_loop
    import agc_ctrl_pkg::*;
();

    localparam int NUM_ROWS   = 9;
    localparam int MAX_CYCLES = NUM_ROWS * 400 + 200;

    typedef struct packed {
        word_t   sum_sq;
        word_t   above;
        word_t   below;
        logic    new_steps;       // Host writes both steps before this row
        scale_t  scale_step;
        offset_t offset_step;
        scale_t  exp_scale;
        offset_t exp_offset;
    } row_t;

    logic        aclk;
    logic        wb_rst;
    logic        agc_reset;
    wb_req_t     host_req;
    wb_rsp_t     host_rsp;
    wb_req_t     agc_req;
    wb_rsp_t     agc_rsp;
    word_t       sum_sq;
    word_t       above;
    word_t       below;
    bus_cmd_t    wr_log;
    bus_cmd_t    wr_q [$];        // Datapath writes in bus order
    row_t        rows [NUM_ROWS];
    int unsigned cycles = 0;

    agc_loop_top dut (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst),
        .agc_reset_i (agc_reset),
        .host_req_i  (host_req),
        .host_rsp_o  (host_rsp),
        .agc_req_o   (agc_req),
        .agc_rsp_i   (agc_rsp)
    );

    agc_target_model u_model (
        .aclk     (aclk),
        .wb_rst_i (wb_rst),
        .req_i    (agc_req),
        .rsp_o    (agc_rsp),
        .sum_sq_i (sum_sq),
        .above_i  (above),
        .below_i  (below),
        .wr_log_o (wr_log)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        if (wr_log.we) wr_q.push_back(wr_log);
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the loop did not finish all rows", cycles);
            $display("RESULT: FAIL");
            $fatal(1, "Run stopped by timeout");
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_scale(input string name, input scale_t got, input scale_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_offset(input string name, input offset_t got, input offset_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    //////////////////////////////////////////////////
    // Host port and datapath log helpers
    //////////////////////////////////////////////////
    task automatic host_write(input bus_addr_t adr, input word_t dat);
        @(posedge aclk);
        host_req <= '{cyc: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do @(posedge aclk); while (!host_rsp.ack);
        host_req <= '0;
    endtask

    task automatic host_read(input bus_addr_t adr, output word_t dat);
        @(posedge aclk);
        host_req <= '{cyc: 1'b1, we: 1'b0, adr: adr, dat: '0};
        do @(posedge aclk); while (!host_rsp.ack);
        dat = host_rsp.dat;       // Valid in the ack cycle
        host_req <= '0;
    endtask

    task automatic expect_write(input string name, input bus_addr_t adr, output word_t dat);
        bus_cmd_t wr;
        while (wr_q.size() == 0) @(negedge aclk);
        wr = wr_q.pop_front();
        check_word({name, " address"}, word_t'(wr.adr), word_t'(adr));
        dat = wr.dat;
    endtask

    task automatic expect_gain(input scale_t exp_scale, input offset_t exp_offset);
        word_t dat;
        expect_write("scale write", `AGC_ADDR_SCALE, dat);
        check_scale("scale write data", dat[`AGC_SCALE_W-1:0], exp_scale);
        expect_write("offset write", `AGC_ADDR_OFFSET, dat);
        check_offset("offset write data", dat[`AGC_OFFSET_W-1:0], exp_offset);
    endtask

    // Load, apply, AGC reset, start
    task automatic expect_commands();
        word_t dat;
        expect_write("load", `AGC_ADDR_CTRL, dat);
        check_word("load command", dat, `AGC_CMD_LOAD);
        expect_write("apply", `AGC_ADDR_CTRL, dat);
        check_word("apply command", dat, `AGC_CMD_APPLY);
        expect_write("agc reset", `AGC_ADDR_CTRL, dat);
        check_word("agc reset command", dat, `AGC_CMD_RESET);
        expect_write("start", `AGC_ADDR_CTRL, dat);
        check_word("start command", dat, `AGC_CMD_START);
    endtask

    task automatic apply_row(input int i);
        @(posedge aclk);
        sum_sq <= rows[i].sum_sq;
        above  <= rows[i].above;
        below  <= rows[i].below;
        if (rows[i].new_steps) begin
            host_write(`HOST_ADDR_SCALE_DELTA, word_t'(rows[i].scale_step));
            host_write(`HOST_ADDR_OFFSET_DELTA,
                       {{(`AGC_DATA_W-`AGC_OFFSET_W){rows[i].offset_step[15]}},
                        rows[i].offset_step});
        end
    endtask

    task automatic fill_table();
        // sum sq, above, below, new steps, scale step, offset step, exp scale, exp offset
        rows[0] = '{32'h0000_8000, 32'd100, 32'd50, 1'b0, 17'd0, 16'sd0, 17'd1530, -16'sd25};
        rows[1] = '{32'h0004_0000, 32'd50, 32'd100, 1'b0, 17'd0, 16'sd0, 17'd1500, 16'sd0};
        rows[2] = '{32'h0002_0000, 32'd60, 32'd64, 1'b0, 17'd0, 16'sd0, 17'd1500, 16'sd0};
        rows[3] = '{32'h0004_0000, 32'd10, 32'd20, 1'b1, 17'd500, 16'sd1000, 17'd1000, 16'sd1000};
        rows[4] = '{32'h0004_0000, 32'd200, 32'd20, 1'b0, 17'd0, 16'sd0, 17'd500, 16'sd0};
        rows[5] = '{32'h0004_0000, 32'd30, 32'd30, 1'b1, 17'd250, 16'sd25, 17'd250, 16'sd0};
        rows[6] = '{32'h0004_0000, 32'd20, 32'd90, 1'b0, 17'd0, 16'sd0, 17'd250, 16'sd25};  // Floor
        rows[7] = '{32'h0000_8000, 32'd40, 32'd40, 1'b1, 17'd129750, 16'sd25, 17'd130000, 16'sd25};
        rows[8] = '{32'h0000_8000, 32'd90, 32'd20, 1'b0, 17'd0, 16'sd0, 17'd130000, 16'sd0};  // Ceiling
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        word_t rd;
        fill_table();
        host_req  = '0;
        wb_rst    = 1'b1;
        agc_reset = 1'b0;
        sum_sq    = '0;
        above     = '0;
        below     = '0;
        repeat (4) @(posedge aclk);
        wb_rst <= 1'b0;
        @(posedge aclk);
        check_word("host ack", word_t'(host_rsp.ack), '0);
        check_word("datapath cyc", word_t'(agc_req.cyc), '0);

        host_read(`HOST_ADDR_SCALE_DELTA, rd);
        check_word("scale step", rd, 32'd30);
        host_read(`HOST_ADDR_OFFSET_DELTA, rd);
        check_word("offset step", rd, 32'd25);

        apply_row(0);
        expect_gain(`AGC_START_SCALE, `AGC_START_OFFSET);
        expect_commands();

        for (int i = 0; i < NUM_ROWS; i++) begin
            expect_gain(rows[i].exp_scale, rows[i].exp_offset);
            if (i + 1 < NUM_ROWS) apply_row(i + 1);    // Lands before the next info reads
            host_read(8'h08, rd);
            check_word("count above", rd, rows[i].above);
            host_read(8'h0C, rd);
            check_word("count below", rd, rows[i].below);
            expect_commands();
        end

        // Restart while the loop polls status
        @(posedge aclk);
        agc_reset <= 1'b1;
        @(posedge aclk);
        agc_reset <= 1'b0;
        @(posedge aclk);
        check_word("datapath cyc after restart", word_t'(agc_req.cyc), '0);
        expect_gain(`AGC_START_SCALE, `AGC_START_OFFSET);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sim/agc_target_model.sv
`timescale 1ns/1ps
`include "agc_ctrl_consts.svh"

module agc_target_model
    import agc_ctrl_pkg::*;
(
    input  logic     aclk,
    input  logic     wb_rst_i,
    input  wb_req_t  req_i,
    output wb_rsp_t  rsp_o,
    input  word_t    sum_sq_i,     // Words 1 to 3 of the current row
    input  word_t    above_i,
    input  word_t    below_i,
    output bus_cmd_t wr_log_o      // we marks one logged write
);

    logic [31:0] lcg_q;
    logic [1:0]  wait_q;           // Cycles left before the next ack
    logic [1:0]  poll_q;           // Status reads since the last start command
    logic        ack_q;
    word_t       dat_q;
    word_t       scale_q;
    word_t       offset_q;
    bus_cmd_t    wr_log_q;
    word_t       rd_word;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Register map of the datapath as seen by the loop
    always_comb begin
        rd_word = '0;
        case (req_i.adr)
            `AGC_ADDR_CTRL:   rd_word[`AGC_STATUS_DONE_BIT] = (poll_q >= 2'd2);  // Third poll
            8'h04:            rd_word = sum_sq_i;
            8'h08:            rd_word = above_i;
            8'h0C:            rd_word = below_i;
            `AGC_ADDR_SCALE:  rd_word = scale_q;
            `AGC_ADDR_OFFSET: rd_word = offset_q;
            default:          rd_word = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Ack engine with random delay
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            lcg_q    <= 32'hfccf7654;
            wait_q   <= '0;
            poll_q   <= '0;
            ack_q    <= 1'b0;
            wr_log_q <= '0;
            scale_q  <= '0;
            offset_q <= '0;
        end else begin
            ack_q    <= 1'b0;
            wr_log_q <= '0;
            if (req_i.cyc && !ack_q) begin
                if (wait_q != '0) begin
                    wait_q <= wait_q - 1'b1;
                end else begin
                    ack_q  <= 1'b1;
                    dat_q  <= rd_word;
                    lcg_q  <= lcg_next(lcg_q);
                    wait_q <= lcg_q[17:16];    // 1 to 4 cycles for the next one
                    if (req_i.we) begin
                        wr_log_q <= '{we: 1'b1, adr: req_i.adr, dat: req_i.dat};
                        if (req_i.adr == `AGC_ADDR_SCALE) begin
                            scale_q <= req_i.dat;
                        end else if (req_i.adr == `AGC_ADDR_OFFSET) begin
                            offset_q <= req_i.dat;
                        end else if (req_i.dat == `AGC_CMD_START) begin
                            poll_q <= '0;
                        end
                    end else if (req_i.adr == `AGC_ADDR_CTRL && poll_q != 2'd3) begin
                        poll_q <= poll_q + 1'b1;
                    end
                end
            end
        end
    end

    assign rsp_o    = '{ack: ack_q, dat: dat_q};
    assign wr_log_o = wr_log_q;

endmodule

// File: design/agc_loop_top.sv
`timescale 1ns/1ps
`include "agc_ctrl_consts.svh"

module agc_loop_top
    import agc_ctrl_pkg::*;
(
    input  logic    aclk,
    input  logic    wb_rst_i,
    input  logic    agc_reset_i,
    input  wb_req_t host_req_i,
    output wb_rsp_t host_rsp_o,
    output wb_req_t agc_req_o,
    input  wb_rsp_t agc_rsp_i
);

    scale_t      scale_delta;
    offset_t     offset_delta;
    info_array_t info;
    logic        cmd_valid;
    bus_cmd_t    cmd;
    logic        cmd_done;
    word_t       rd_data;

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////
    agc_host_regs u_host_regs (
        .aclk           (aclk),
        .wb_rst_i       (wb_rst_i),
        .host_req_i     (host_req_i),
        .host_rsp_o     (host_rsp_o),
        .info_i         (info),
        .scale_delta_o  (scale_delta),
        .offset_delta_o (offset_delta)
    );

    // Control loop
    agc_loop_seq u_loop_seq (
        .aclk           (aclk),
        .wb_rst_i       (wb_rst_i),
        .agc_reset_i    (agc_reset_i),
        .scale_delta_i  (scale_delta),
        .offset_delta_i (offset_delta),
        .info_o         (info),
        .cmd_valid_o    (cmd_valid),
        .cmd_o          (cmd),
        .cmd_done_i     (cmd_done),
        .rd_data_i      (rd_data)
    );

    // Datapath side
    agc_bus_master u_bus_master (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .cmd_done_o  (cmd_done),
        .rd_data_o   (rd_data),
        .agc_req_o   (agc_req_o),
        .agc_rsp_i   (agc_rsp_i)
    );

endmodule

// File: design/agc_bus_master.sv
`timescale 1ns/1ps
`include "agc_ctrl_consts.svh"

module agc_bus_master
    import agc_ctrl_pkg::*;
(
    input  logic     aclk,
    input  logic     wb_rst_i,
    input  logic     agc_reset_i,
    input  logic     cmd_valid_i,
    input  bus_cmd_t cmd_i,
    output logic     cmd_done_o,
    output word_t    rd_data_o,
    output wb_req_t  agc_req_o,
    input  wb_rsp_t  agc_rsp_i
);

    logic     busy_q;      // Idle or in flight, one transaction at a time
    logic     done_q;
    bus_cmd_t cmd_q;
    word_t    rd_data_q;

    //////////////////////////////////////////////////
    // Transaction engine
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                if (cmd_valid_i) begin
                    busy_q <= 1'b1;         // cyc goes up next cycle
                end
            end else if (agc_rsp_i.ack) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;             // Same cycle that cyc drops
            end
        end
    end

    // Command latch and read capture
    always_ff @(posedge aclk) begin
        if (!busy_q && cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
        if (busy_q && agc_rsp_i.ack) begin
            rd_data_q <= agc_rsp_i.dat;
        end
    end

    assign agc_req_o = '{
        cyc: busy_q,
        we:  cmd_q.we,
        adr: cmd_q.adr,
        dat: cmd_q.dat
    };

    assign cmd_done_o = done_q;
    assign rd_data_o  = rd_data_q;

endmodule

// File: design/agc_loop_seq.sv
`timescale 1ns/1ps
`include "agc_ctrl_consts.svh"

module agc_loop_seq
    import agc_ctrl_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  logic        agc_reset_i,
    input  scale_t      scale_delta_i,
    input  offset_t     offset_delta_i,
    output info_array_t info_o,
    output logic        cmd_valid_o,
    output bus_cmd_t    cmd_o,
    input  logic        cmd_done_i,
    input  word_t       rd_data_i
);

    localparam int BOOT_W = $clog2(`AGC_BOOT_DELAY + 1);

    // Positions in the info array
    localparam info_idx_t IDX_SUM_SQ = 3'd1;
    localparam info_idx_t IDX_ABOVE  = 3'd2;
    localparam info_idx_t IDX_BELOW  = 3'd3;
    localparam info_idx_t IDX_SCALE  = 3'd4;
    localparam info_idx_t IDX_OFFSET = 3'd5;

    loop_state_e       state_q;
    logic              busy_q;        // Command out, cmd_done not yet seen
    info_idx_t         idx_q;         // Write select, then read pointer
    logic [BOOT_W-1:0] boot_cnt_q;
    scale_t            scale_q;
    offset_t           offset_q;
    info_array_t       info_q;
    logic              cmd_valid_q;
    bus_cmd_t          cmd_q;

    bus_cmd_t          cmd_next;
    logic              issue;
    logic              done;
    rms_sq_t           rms_sq;
    scale_t            scale_next;
    offset_t           offset_next;

    assign done = busy_q && cmd_done_i;

    //////////////////////////////////////////////////
    // Command for the current state
    //////////////////////////////////////////////////
    always_comb begin
        cmd_next = '0;
        issue    = 1'b1;
        case (state_q)
            LOOP_WRITING: begin
                cmd_next.we = 1'b1;
                if (idx_q == '0) begin
                    cmd_next.adr = `AGC_ADDR_SCALE;
                    cmd_next.dat = word_t'(scale_q);
                end else begin
                    cmd_next.adr = `AGC_ADDR_OFFSET;
                    cmd_next.dat = {{(`AGC_DATA_W-`AGC_OFFSET_W){offset_q[15]}}, offset_q};
                end
            end
            LOOP_LOADING: begin
                cmd_next = '{we: 1'b1, adr: `AGC_ADDR_CTRL, dat: `AGC_CMD_LOAD};
            end
            LOOP_APPLYING: begin
                cmd_next = '{we: 1'b1, adr: `AGC_ADDR_CTRL, dat: `AGC_CMD_APPLY};
            end
            LOOP_RESETTING: begin
                cmd_next = '{we: 1'b1, adr: `AGC_ADDR_CTRL, dat: `AGC_CMD_RESET};
            end
            LOOP_STARTING: begin
                cmd_next = '{we: 1'b1, adr: `AGC_ADDR_CTRL, dat: `AGC_CMD_START};
            end
            LOOP_WAITING:  cmd_next.adr = `AGC_ADDR_CTRL;            // Status poll
            LOOP_READING:  cmd_next.adr = bus_addr_t'({idx_q, 2'b00});
            default:       issue = 1'b0;    // Boot delay and calculation
        endcase
    end

    //////////////////////////////////////////////////
    // Step calculation
    //////////////////////////////////////////////////
    always_comb begin
        rms_sq     = rms_sq_t'(info_q[IDX_SUM_SQ][24:17-`AGC_TIMESCALE_BITS]);
        scale_next = scale_q;
        if (rms_sq > (`AGC_TARGET_RMS_SQ + `AGC_RMS_SQ_ERR)) begin
            if (info_q[IDX_SCALE] > `AGC_SCALE_MIN) begin
                scale_next = info_q[IDX_SCALE][`AGC_SCALE_W-1:0] - scale_delta_i;
            end else begin
                scale_next = info_q[IDX_SCALE][`AGC_SCALE_W-1:0];  // Pinned at floor
            end
        end else if (rms_sq < (`AGC_TARGET_RMS_SQ - `AGC_RMS_SQ_ERR)) begin
            if (info_q[IDX_SCALE] < `AGC_SCALE_MAX) begin
                scale_next = info_q[IDX_SCALE][`AGC_SCALE_W-1:0] + scale_delta_i;
            end else begin
                scale_next = info_q[IDX_SCALE][`AGC_SCALE_W-1:0];  // Pinned at ceiling
            end
        end

        // Offset follows the above/below balance, wraps at 16 bits
        offset_next = offset_q;
        if (info_q[IDX_ABOVE] > info_q[IDX_BELOW] + `AGC_OFFSET_ERR) begin
            offset_next = info_q[IDX_OFFSET][`AGC_OFFSET_W-1:0] - offset_delta_i;
        end else if (info_q[IDX_BELOW] > info_q[IDX_ABOVE] + `AGC_OFFSET_ERR) begin
            offset_next = info_q[IDX_OFFSET][`AGC_OFFSET_W-1:0] + offset_delta_i;
        end
    end

    //////////////////////////////////////////////////
    // Loop FSM
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state_q     <= LOOP_BOOT_DELAY;
            busy_q      <= 1'b0;
            idx_q       <= '0;
            boot_cnt_q  <= BOOT_W'(`AGC_BOOT_DELAY);
            scale_q     <= `AGC_START_SCALE;
            offset_q    <= `AGC_START_OFFSET;
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= issue && !busy_q;
            if (issue && !busy_q) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end

            case (state_q)
                LOOP_BOOT_DELAY: begin
                    if (boot_cnt_q != '0) begin
                        boot_cnt_q <= boot_cnt_q - 1'b1;
                    end else begin
                        state_q <= LOOP_WRITING;
                        idx_q   <= '0;
                    end
                end
                LOOP_WRITING: begin
                    if (done) begin
                        if (idx_q == '0) begin
                            idx_q <= 3'd1;         // Offset next
                        end else begin
                            idx_q   <= '0;
                            state_q <= LOOP_LOADING;
                        end
                    end
                end
                LOOP_LOADING:   if (done) state_q <= LOOP_APPLYING;
                LOOP_APPLYING:  if (done) state_q <= LOOP_RESETTING;
                LOOP_RESETTING: if (done) state_q <= LOOP_STARTING;
                LOOP_STARTING:  if (done) state_q <= LOOP_WAITING;
                LOOP_WAITING: begin
                    // Not done yet means another poll
                    if (done && rd_data_i[`AGC_STATUS_DONE_BIT]) begin
                        state_q <= LOOP_READING;
                        idx_q   <= '0;
                    end
                end
                LOOP_READING: begin
                    if (done) begin
                        if (idx_q == info_idx_t'(`AGC_INFO_WORDS - 1)) begin
                            idx_q   <= '0;
                            state_q <= LOOP_CALCULATING;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    scale_q  <= scale_next;
                    offset_q <= offset_next;
                    state_q  <= LOOP_WRITING;
                    idx_q    <= '0;
                end
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge aclk) begin
        if (issue && !busy_q) begin
            cmd_q <= cmd_next;
        end
        if (state_q == LOOP_READING && done) begin
            info_q[idx_q] <= rd_data_i;
        end
    end

    assign cmd_valid_o = cmd_valid_q;
    assign cmd_o       = cmd_q;
    assign info_o      = info_q;

endmodule

// File: design/agc_host_regs.sv
`timescale 1ns/1ps
`include "agc_ctrl_consts.svh"

module agc_host_regs
    import agc_ctrl_pkg::*;
(
    input  logic        aclk,
    input  logic        wb_rst_i,
    input  wb_req_t     host_req_i,
    output wb_rsp_t     host_rsp_o,
    input  info_array_t info_i,
    output scale_t      scale_delta_o,
    output offset_t     offset_delta_o
);

    host_state_e state_q;
    word_t       rsp_dat_q;       // Read data held for the ack cycle
    scale_t      scale_delta_q;
    offset_t     offset_delta_q;
    word_t       rd_word;
    info_idx_t   info_idx;

    assign info_idx = host_req_i.adr[4:2];

    // Read mux, bit 6 picks the step registers over the info words
    always_comb begin
        rd_word = '0;
        if (host_req_i.adr[6]) begin
            case (host_req_i.adr)
                `HOST_ADDR_SCALE_DELTA:  rd_word = word_t'(scale_delta_q);
                `HOST_ADDR_OFFSET_DELTA: rd_word = {{(`AGC_DATA_W-`AGC_OFFSET_W){offset_delta_q[15]}},
                                                    offset_delta_q};
                default:                 rd_word = '0;
            endcase
        end else if (host_req_i.adr[5:2] < `AGC_INFO_WORDS) begin
            rd_word = info_i[info_idx];
        end
    end

    //////////////////////////////////////////////////
    // Target FSM
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state_q        <= HOST_IDLE;
            scale_delta_q  <= `AGC_START_SCALE_DELTA;
            offset_delta_q <= `AGC_START_OFFSET_DELTA;
        end else begin
            case (state_q)
                HOST_IDLE: begin
                    if (host_req_i.cyc) begin
                        state_q <= host_req_i.we ? HOST_WRITE : HOST_READ;
                    end
                end
                HOST_WRITE: begin
                    // Writes outside the step registers are acked and dropped
                    if (host_req_i.adr == `HOST_ADDR_SCALE_DELTA) begin
                        scale_delta_q <= host_req_i.dat[`AGC_SCALE_W-1:0];
                    end else if (host_req_i.adr == `HOST_ADDR_OFFSET_DELTA) begin
                        offset_delta_q <= host_req_i.dat[`AGC_OFFSET_W-1:0];
                    end
                    state_q <= HOST_ACK;
                end
                HOST_READ: state_q <= HOST_ACK;
                default:   state_q <= HOST_IDLE;    // Ack lasts one cycle
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state_q == HOST_READ) begin
            rsp_dat_q <= rd_word;
        end
    end

    assign host_rsp_o = '{ack: (state_q == HOST_ACK), dat: rsp_dat_q};

    assign scale_delta_o  = scale_delta_q;
    assign offset_delta_o = offset_delta_q;

endmodule

// File: design/agc_ctrl_pkg.sv
`include "agc_ctrl_consts.svh"

package agc_ctrl_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////
    typedef logic [`AGC_DATA_W-1:0]          word_t;
    typedef logic [`AGC_ADDR_W-1:0]          bus_addr_t;
    typedef logic [`AGC_SCALE_W-1:0]         scale_t;     // Unsigned gain
    typedef logic signed [`AGC_OFFSET_W-1:0] offset_t;    // Two's complement offset
    typedef logic [24:0]                     rms_sq_t;    // Mean square after timescale cut
    typedef logic [2:0]                      info_idx_t;

    // Status, sum of squares, above, below, scale, offset
    typedef word_t [`AGC_INFO_WORDS-1:0] info_array_t;

    //////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////
    typedef struct packed {
        logic      cyc;
        logic      we;
        bus_addr_t adr;
        word_t     dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // One datapath transaction as handed to the bus master
    typedef struct packed {
        logic      we;
        bus_addr_t adr;
        word_t     dat;
    } bus_cmd_t;

    // State machines
    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_WRITE,
        HOST_READ,
        HOST_ACK
    } host_state_e;

    typedef enum logic [3:0] {
        LOOP_BOOT_DELAY,
        LOOP_WRITING,
        LOOP_LOADING,
        LOOP_APPLYING,
        LOOP_RESETTING,
        LOOP_STARTING,
        LOOP_WAITING,
        LOOP_READING,
        LOOP_CALCULATING
    } loop_state_e;

endpackage

// File: design/agc_ctrl_consts.svh
`ifndef AGC_CTRL_CONSTS_SVH
`define AGC_CTRL_CONSTS_SVH

//////////////////////////////////////////////////
// Bus and data widths
//////////////////////////////////////////////////
`define AGC_ADDR_W              8
`define AGC_DATA_W              32
`define AGC_INFO_WORDS          6
`define AGC_SCALE_W             17
`define AGC_OFFSET_W            16

// Values loaded on reset
`define AGC_START_SCALE         17'd1500
`define AGC_START_OFFSET        16'd0
`define AGC_START_SCALE_DELTA   17'd30
`define AGC_START_OFFSET_DELTA  16'd25

//////////////////////////////////////////////////
// Loop limits
//////////////////////////////////////////////////
`define AGC_SCALE_MIN           32'h0001_2C     // Lowest scale the loop steps down to
`define AGC_SCALE_MAX           32'h0001_FBD0   // Highest scale the loop steps up to
`define AGC_TARGET_RMS_SQ       16
`define AGC_RMS_SQ_ERR          0
`define AGC_OFFSET_ERR          5               // Allowed above/below imbalance
`define AGC_TIMESCALE_BITS      4
`define AGC_BOOT_DELAY          31

// Command words for control register 0
`define AGC_CMD_START           32'h0000_0001
`define AGC_CMD_RESET           32'h0000_0004
`define AGC_CMD_LOAD            32'h0000_0300
`define AGC_CMD_APPLY           32'h0000_0400

// Register map
`define AGC_STATUS_DONE_BIT     1
`define AGC_ADDR_CTRL           8'h00
`define AGC_ADDR_SCALE          8'h10
`define AGC_ADDR_OFFSET         8'h14
`define HOST_ADDR_SCALE_DELTA   8'h40
`define HOST_ADDR_OFFSET_DELTA  8'h44

`endif
